//--- include/mesh_tb_checks.svh
/* Testbench checks and APB access tasks
   Typed compares and bounded APB read and write transfers for the tile row */
`ifndef MESH_TB_CHECKS_SVH
`define MESH_TB_CHECKS_SVH

task automatic check_data(input string name, input mesh_pkg::data_t exp,
                          input mesh_pkg::data_t act);
  if (act !== exp) begin
    $display("error %s expected %08h actual %08h", name, exp, act);
    stop_on_failure();
  end
endtask

task automatic check_op(input string name, input mesh_pkg::opcode_e exp,
                        input mesh_pkg::opcode_e act);
  if (act !== exp) begin
    $display("error %s expected %s actual %s", name, exp.name(), act.name());
    stop_on_failure();
  end
endtask

task automatic check_x(input string name, input mesh_pkg::x_cord_t exp,
                       input mesh_pkg::x_cord_t act);
  if (act !== exp) begin
    $display("error %s expected x %0d actual x %0d", name, exp, act);
    stop_on_failure();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("error %s expected %b actual %b", name, exp, act);
    stop_on_failure();
  end
endtask

// One APB transfer, completes on the edge after PREADY is seen high
task automatic apb_access(input logic [7:0] addr, input logic write,
                          input mesh_pkg::data_t wdata,
                          output mesh_pkg::data_t rdata, output logic err);
  int waited;
  waited = 0;
  @(posedge clk);
  psel    <= 1'b1;  // Setup phase
  penable <= 1'b0;
  pwrite  <= write;
  paddr   <= addr;
  pwdata  <= wdata;
  @(posedge clk);
  penable <= 1'b1;
  @(negedge clk);
  while (!pready) begin
    if (waited == apb_timeout_lp) begin
      report_timeout("APB transfer never saw PREADY high");
    end else begin
      waited++;
      @(negedge clk);
    end
  end
  rdata = prdata;  // Stable mid-cycle
  err   = pslverr;
  @(posedge clk);
  psel    <= 1'b0;
  penable <= 1'b0;
endtask

task automatic apb_write(input logic [7:0] addr, input mesh_pkg::data_t wdata,
                         output logic err);
  mesh_pkg::data_t unused;
  apb_access(addr, 1'b1, wdata, unused, err);
endtask

task automatic apb_read(input logic [7:0] addr, output mesh_pkg::data_t rdata,
                        output logic err);
  apb_access(addr, 1'b0, '0, rdata, err);
endtask

`endif

//--- dv/mesh_row_tb.sv
/* Testbench for the tile row
   APB stimulus, reference memory model and a response comparing process */
module mesh_row_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int apb_timeout_lp  = 200;  // Cycles per transfer
  localparam int poll_timeout_lp = 100;  // Status reads per poll
  localparam int random_ops_lp   = 200;

  logic            clk;
  logic            rst_n;
  logic [7:0]      paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  mesh_pkg::data_t pwdata;
  mesh_pkg::data_t prdata;
  logic            pready;
  logic            pslverr;

  string test_name;

  mesh_pkg::data_t ref_mem [mesh_pkg::num_tiles_lp][mesh_pkg::mem_words_lp];

  // Outstanding requests in issue order, and responses read back
  mesh_pkg::opcode_e exp_op_q [$];
  mesh_pkg::x_cord_t exp_x_q [$];
  mesh_pkg::data_t   exp_data_q [$];
  mesh_pkg::opcode_e obs_op_q [$];
  mesh_pkg::x_cord_t obs_x_q [$];
  mesh_pkg::data_t   obs_data_q [$];

  mesh_row dut (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.paddr_i(paddr)
    ,.psel_i(psel)
    ,.penable_i(penable)
    ,.pwrite_i(pwrite)
    ,.pwdata_i(pwdata)
    ,.prdata_o(prdata)
    ,.pready_o(pready)
    ,.pslverr_o(pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s: %s", test_name, what);
    stop_on_failure();
  endtask

  `include "mesh_tb_checks.svh"

  // Expected response of one request, model updated on stores
  function automatic void ref_resp(input mesh_pkg::opcode_e op, input mesh_pkg::x_cord_t x,
                                   input mesh_pkg::addr_t addr, input mesh_pkg::data_t data,
                                   output mesh_pkg::opcode_e exp_op,
                                   output mesh_pkg::data_t exp_data);
    if (op == mesh_pkg::op_store) begin
      ref_mem[x][addr] = data;
      exp_op   = mesh_pkg::op_store_resp;
      exp_data = data;  // Store acknowledge echoes the word
    end else begin
      exp_op   = mesh_pkg::op_load_resp;
      exp_data = ref_mem[x][addr];
    end
  endfunction

  task automatic issue_req(input mesh_pkg::opcode_e op, input mesh_pkg::x_cord_t x,
                           input mesh_pkg::addr_t addr, input mesh_pkg::data_t data);
    mesh_pkg::opcode_e exp_op;
    mesh_pkg::data_t   exp_data;
    logic              err;
    apb_write(mesh_pkg::reg_data_lp, data, err);
    check_bit(test_name, 1'b0, err);
    apb_write(mesh_pkg::reg_req_lp, mesh_pkg::data_t'({op, x, addr}), err);
    check_bit(test_name, 1'b0, err);
    ref_resp(op, x, addr, data, exp_op, exp_data);
    exp_op_q.push_back(exp_op);
    exp_x_q.push_back(x);
    exp_data_q.push_back(exp_data);
  endtask

  // Poll reg_status until the count reaches min_cnt
  task automatic wait_for_count(input int min_cnt, output mesh_pkg::data_t status);
    logic err;
    int   polls;
    polls = 0;
    apb_read(mesh_pkg::reg_status_lp, status, err);
    while (int'(status[2:0]) < min_cnt) begin
      if (polls == poll_timeout_lp) begin
        report_timeout("status count never reached the expected level");
      end else begin
        polls++;
        apb_read(mesh_pkg::reg_status_lp, status, err);
      end
    end
  endtask

  task automatic drain(input int n);
    mesh_pkg::data_t status;
    mesh_pkg::data_t data;
    logic            err;
    int              waited;
    for (int i = 0; i < n; i++) begin
      wait_for_count(1, status);
      apb_read(mesh_pkg::reg_resp_lp, data, err);  // Pops the head
      check_bit(test_name, 1'b0, err);
      obs_op_q.push_back(mesh_pkg::opcode_e'(status[5:4]));
      obs_x_q.push_back(mesh_pkg::x_cord_t'(status[7:6]));
      obs_data_q.push_back(data);
    end
    waited = 0;
    while (obs_op_q.size() != 0) begin
      if (waited == apb_timeout_lp) begin
        report_timeout("comparing process did not consume responses");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  // Match each response to the oldest request for its tile
  always @(posedge clk) begin
    int idx;
    while (obs_op_q.size() != 0) begin
      idx = -1;
      for (int i = 0; i < exp_x_q.size(); i++) begin
        if (idx < 0 && exp_x_q[i] == obs_x_q[0]) idx = i;
      end
      if (exp_x_q.size() == 0) begin
        $display("%s: response from tile %0d with no request outstanding",
                 test_name, obs_x_q[0]);
        stop_on_failure();
      end else if (idx < 0) begin
        check_x(test_name, exp_x_q[0], obs_x_q[0]);
      end else begin
        check_op(test_name, exp_op_q[idx], obs_op_q[0]);
        check_data(test_name, exp_data_q[idx], obs_data_q[0]);
        exp_op_q.delete(idx);
        exp_x_q.delete(idx);
        exp_data_q.delete(idx);
      end
      void'(obs_op_q.pop_front());
      void'(obs_x_q.pop_front());
      void'(obs_data_q.pop_front());
    end
  end

  initial begin
    mesh_pkg::data_t   rd;
    mesh_pkg::data_t   d;
    mesh_pkg::x_cord_t t;
    mesh_pkg::addr_t   a;
    mesh_pkg::opcode_e op;
    logic              err;
    int                issued;
    int                batch;
    test_name = "reset";
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    void'($urandom(32'h4ca7));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);  // Tile resets release two flops later

    check_bit(test_name, 1'b1, pready);  // Idle bus
    apb_read(mesh_pkg::reg_status_lp, rd, err);
    check_data(test_name, '0, mesh_pkg::data_t'(rd[2:0]));
    apb_read(mesh_pkg::reg_resp_lp, rd, err);
    check_bit(test_name, 1'b1, err);  // Empty queue
    check_data(test_name, '0, rd);

    test_name = "store_load";
    for (int x = 0; x < mesh_pkg::num_tiles_lp; x++) begin
      issue_req(mesh_pkg::op_store, mesh_pkg::x_cord_t'(x), 4'd5, $urandom());
      issue_req(mesh_pkg::op_load, mesh_pkg::x_cord_t'(x), 4'd5, '0);
      drain(2);
    end

    test_name = "tile_separation";
    for (int x = 0; x < mesh_pkg::num_tiles_lp; x++) begin
      issue_req(mesh_pkg::op_store, mesh_pkg::x_cord_t'(x), 4'd9, 32'h1000_0000 * (x + 1));
    end
    drain(mesh_pkg::num_tiles_lp);
    for (int x = mesh_pkg::num_tiles_lp - 1; x >= 0; x--) begin
      issue_req(mesh_pkg::op_load, mesh_pkg::x_cord_t'(x), 4'd9, '0);
    end
    drain(mesh_pkg::num_tiles_lp);

    test_name = "random";
    issued = 0;
    while (issued < random_ops_lp) begin
      batch = 1 + ($urandom() % mesh_pkg::resp_depth_lp);
      if (batch > random_ops_lp - issued) batch = random_ops_lp - issued;
      for (int i = 0; i < batch; i++) begin
        t = mesh_pkg::x_cord_t'($urandom());
        a = mesh_pkg::addr_t'($urandom());
        d = $urandom();
        // Loads only where the model holds a known word
        if ($urandom() % 2 == 0 || $isunknown(ref_mem[t][a])) op = mesh_pkg::op_store;
        else op = mesh_pkg::op_load;
        issue_req(op, t, a, d);
      end
      drain(batch);
      issued += batch;
    end

    test_name = "backpressure";
    for (int i = 0; i < mesh_pkg::resp_depth_lp + 3; i++) begin
      issue_req(mesh_pkg::op_store, 2'd0, mesh_pkg::addr_t'(i), 32'hb0b0_0000 + i);
    end
    wait_for_count(mesh_pkg::resp_depth_lp, rd);
    repeat (20) @(posedge clk);
    apb_read(mesh_pkg::reg_status_lp, rd, err);
    check_data(test_name, mesh_pkg::resp_depth_lp, mesh_pkg::data_t'(rd[2:0]));
    drain(mesh_pkg::resp_depth_lp + 3);

    test_name = "bad_opcode";
    apb_write(mesh_pkg::reg_req_lp, mesh_pkg::data_t'({mesh_pkg::op_load_resp, 2'd1, 4'd3}),
              err);
    check_bit(test_name, 1'b1, err);
    apb_write(mesh_pkg::reg_req_lp, mesh_pkg::data_t'({mesh_pkg::op_store_resp, 2'd2, 4'd7}),
              err);
    check_bit(test_name, 1'b1, err);
    repeat (40) @(posedge clk);  // Longer than a round trip to the far tile
    apb_read(mesh_pkg::reg_status_lp, rd, err);
    check_data(test_name, '0, mesh_pkg::data_t'(rd[2:0]));

    if (exp_op_q.size() != 0) begin
      $display("%0d requests never got a response", exp_op_q.size());
      stop_on_failure();
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- hdl/apb_host_bridge.sv
/* APB host port of the row
   Turns register writes into request packets and queues returned responses */
module apb_host_bridge (
  input  logic                clk_i
  , input  logic                rst_n_i
  , input  logic [7:0]          paddr_i
  , input  logic                psel_i
  , input  logic                penable_i
  , input  logic                pwrite_i
  , input  mesh_pkg::data_t     pwdata_i
  , output mesh_pkg::data_t     prdata_o
  , output logic                pready_o
  , output logic                pslverr_o
  , output mesh_pkg::packet_t   req_o
  , output logic                req_valid_o
  , input  logic                req_ready_i
  , input  mesh_pkg::packet_t   resp_i
  , input  logic                resp_valid_i
  , output logic                resp_ready_o
);

  localparam int hdr_msb_lp = mesh_pkg::pkt_width_lp - mesh_pkg::pkt_addr_lsb_lp - 1;

  mesh_pkg::data_t   data_q;
  mesh_pkg::packet_t req_q;
  logic              req_valid_q;
  logic [mesh_pkg::cnt_width_lp-1:0] resp_cnt_q;

  mesh_pkg::packet_t head;
  logic              head_valid;
  logic              head_pop;
  mesh_pkg::x_cord_t head_x;
  mesh_pkg::opcode_e head_op;

  mesh_pkg::opcode_e wr_op;
  logic access;
  logic wr_req;
  logic wr_bad;
  logic launch;
  logic rd_resp;
  logic push;

  assign access  = psel_i & penable_i;
  assign wr_op   = mesh_pkg::opcode_e'(pwdata_i[hdr_msb_lp -: mesh_pkg::op_width_lp]);
  assign wr_req  = access & pwrite_i & (paddr_i == mesh_pkg::reg_req_lp);
  assign launch  = wr_req & (wr_op inside {mesh_pkg::op_load, mesh_pkg::op_store});
  assign wr_bad  = wr_req & ~launch;  // Response opcode from the host
  assign rd_resp = access & ~pwrite_i & (paddr_i == mesh_pkg::reg_resp_lp);

  // Launching write completes only with the link handshake
  assign pready_o  = ~launch | (req_valid_q & req_ready_i);
  assign pslverr_o = wr_bad | (rd_resp & ~head_valid);

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_q <= 1'b0;
    end else if (launch && !req_valid_q) begin
      req_valid_q <= 1'b1;
    end else if (req_valid_q && req_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && pwrite_i && paddr_i == mesh_pkg::reg_data_lp) data_q <= pwdata_i;
    if (launch && !req_valid_q) req_q <= {pwdata_i[hdr_msb_lp:0], data_q};
  end

  link_fifo #(.depth(mesh_pkg::resp_depth_lp)) resp_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.data_i(resp_i)
    ,.valid_i(resp_valid_i)
    ,.ready_o(resp_ready_o)
    ,.data_o(head)
    ,.valid_o(head_valid)
    ,.ready_i(head_pop)
  );

  assign push     = resp_valid_i & resp_ready_o;
  assign head_pop = rd_resp & head_valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_cnt_q <= '0;
    end else begin
      case ({push, head_pop})
        2'b10:   resp_cnt_q <= resp_cnt_q + 1'b1;
        2'b01:   resp_cnt_q <= resp_cnt_q - 1'b1;
        default: resp_cnt_q <= resp_cnt_q;
      endcase
    end
  end

  // Head fields read as zero on an empty queue
  assign head_x  = head_valid ? head[mesh_pkg::pkt_x_lsb_lp +: mesh_pkg::x_width_lp] : '0;
  assign head_op = head_valid ?
      mesh_pkg::opcode_e'(head[mesh_pkg::pkt_op_lsb_lp +: mesh_pkg::op_width_lp]) :
      mesh_pkg::op_load;

  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i && paddr_i == mesh_pkg::reg_status_lp) begin
      prdata_o = mesh_pkg::data_t'({head_x, head_op, 1'b0, resp_cnt_q});
    end else if (head_pop) begin
      prdata_o = head[mesh_pkg::pkt_data_lsb_lp +: mesh_pkg::data_width_lp];
    end
  end

  // Tile 0 holds a stalled response until the queue takes it
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_valid_i && !resp_ready_o |=> resp_valid_i && $stable(resp_i))
    else $error("response link changed while stalled");

endmodule

//--- hdl/link_fifo.sv
/* Valid/ready packet FIFO
   Circular buffer used for link buffering and the host response queue */
module link_fifo #(
  parameter int depth = 2
) (
  input  logic              clk_i
  , input  logic              rst_n_i
  , input  mesh_pkg::packet_t data_i
  , input  logic              valid_i
  , output logic              ready_o
  , output mesh_pkg::packet_t data_o
  , output logic              valid_o
  , input  logic              ready_i
);

  mesh_pkg::packet_t mem_q [depth];
  logic [$clog2(depth)-1:0]   wr_ptr_q;
  logic [$clog2(depth)-1:0]   rd_ptr_q;
  logic [$clog2(depth+1)-1:0] count_q;
  logic push;
  logic pop;

  assign ready_o = (count_q != depth);
  assign valid_o = (count_q != 0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == depth - 1) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == depth - 1) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or pass-through
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= depth)
    else $error("link_fifo count %0d above depth %0d", count_q, depth);

endmodule

//--- hdl/mem_socket.sv
/* Tile memory endpoint
   Executes loads and stores on a local word memory and returns responses */
module mem_socket (
  input  logic                clk_i
  , input  logic                rst_n_i
  , input  mesh_pkg::x_cord_t   my_x_i
  , input  mesh_pkg::packet_t   req_i
  , input  logic                req_valid_i
  , output logic                req_ready_o
  , output mesh_pkg::packet_t   resp_o
  , output logic                resp_valid_o
  , input  logic                resp_ready_i
);

  mesh_pkg::data_t   mem_q [mesh_pkg::mem_words_lp];
  mesh_pkg::packet_t resp_q;
  logic              resp_valid_q;

  mesh_pkg::opcode_e req_op;
  mesh_pkg::addr_t   req_addr;
  mesh_pkg::data_t   req_data;
  mesh_pkg::opcode_e resp_op;
  mesh_pkg::data_t   resp_data;
  logic              accept;
  logic              is_store;

  assign req_op   = mesh_pkg::opcode_e'(req_i[mesh_pkg::pkt_op_lsb_lp +: mesh_pkg::op_width_lp]);
  assign req_addr = req_i[mesh_pkg::pkt_addr_lsb_lp +: mesh_pkg::addr_width_lp];
  assign req_data = req_i[mesh_pkg::pkt_data_lsb_lp +: mesh_pkg::data_width_lp];
  assign is_store = (req_op == mesh_pkg::op_store);

  // One response slot, refilled in the cycle it drains
  assign req_ready_o = ~resp_valid_q | resp_ready_i;
  assign accept      = req_valid_i & req_ready_o;

  assign resp_op   = is_store ? mesh_pkg::op_store_resp : mesh_pkg::op_load_resp;
  assign resp_data = is_store ? req_data : mem_q[req_addr];  // Store echoes its data

  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_store) mem_q[req_addr] <= req_data;
    if (accept) resp_q <= {resp_op, my_x_i, req_addr, resp_data};  // Source is this tile
  end

  // The host bridge filters opcodes, so only requests reach a socket
  a_req_opcode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (req_op inside {mesh_pkg::op_load, mesh_pkg::op_store}))
    else $error("socket %0d got opcode %s", my_x_i, req_op.name());

endmodule

//--- hdl/mesh_pkg.sv
/* Shared definitions for the tile row
   Widths, packet layout, opcodes and the host register map */
package mesh_pkg;

  localparam int num_tiles_lp = 4;

  localparam int x_width_lp    = 2;
  localparam int addr_width_lp = 4;
  localparam int data_width_lp = 32;
  localparam int op_width_lp   = 2;
  localparam int pkt_width_lp  = op_width_lp + x_width_lp + addr_width_lp + data_width_lp;

  localparam int mem_words_lp = 1 << addr_width_lp;  // Words per socket memory

  // Packet layout is {opcode, x, addr, data}
  localparam int pkt_data_lsb_lp = 0;
  localparam int pkt_addr_lsb_lp = pkt_data_lsb_lp + data_width_lp;
  localparam int pkt_x_lsb_lp    = pkt_addr_lsb_lp + addr_width_lp;
  localparam int pkt_op_lsb_lp   = pkt_x_lsb_lp + x_width_lp;

  // Host side response queue
  localparam int resp_depth_lp = 4;
  localparam int cnt_width_lp  = 3;  // Status count field

  // APB register map
  localparam logic [7:0] reg_req_lp    = 8'h00;
  localparam logic [7:0] reg_data_lp   = 8'h04;
  localparam logic [7:0] reg_status_lp = 8'h08;
  localparam logic [7:0] reg_resp_lp   = 8'h0C;

  typedef logic [x_width_lp-1:0]    x_cord_t;
  typedef logic [addr_width_lp-1:0] addr_t;
  typedef logic [data_width_lp-1:0] data_t;
  typedef logic [pkt_width_lp-1:0]  packet_t;

  // Requests travel east, responses west
  typedef enum logic [op_width_lp-1:0] {
    op_load       = 2'd0,
    op_store      = 2'd1,
    op_load_resp  = 2'd2,
    op_store_resp = 2'd3
  } opcode_e;

endpackage

//--- hdl/mesh_router.sv
/* Tile router node
   Steers requests east or into the socket, merges responses westward */
module mesh_router (
  input  logic                clk_i
  , input  logic                rst_n_i
  , input  mesh_pkg::x_cord_t   my_x_i
  // Eastbound requests
  , input  mesh_pkg::packet_t   req_w_i
  , input  logic                req_w_valid_i
  , output logic                req_w_ready_o
  , output mesh_pkg::packet_t   req_e_o
  , output logic                req_e_valid_o
  , input  logic                req_e_ready_i
  // Local socket
  , output mesh_pkg::packet_t   proc_req_o
  , output logic                proc_req_valid_o
  , input  logic                proc_req_ready_i
  , input  mesh_pkg::packet_t   proc_resp_i
  , input  logic                proc_resp_valid_i
  , output logic                proc_resp_ready_o
  // Westbound responses
  , input  mesh_pkg::packet_t   resp_e_i
  , input  logic                resp_e_valid_i
  , output logic                resp_e_ready_o
  , output mesh_pkg::packet_t   resp_w_o
  , output logic                resp_w_valid_o
  , input  logic                resp_w_ready_i
);

  mesh_pkg::packet_t req_head;
  logic              req_head_valid;
  logic              req_head_ready;
  mesh_pkg::x_cord_t req_dest;
  logic              to_local;

  mesh_pkg::packet_t resp_e_head;
  logic              resp_e_head_valid;
  logic              resp_e_head_ready;

  logic prio_e_q;      // East response wins the next tie
  logic hold_q;        // Output stalled last cycle
  logic hold_sel_e_q;
  logic sel_e;

  link_fifo #(.depth(2)) req_w_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.data_i(req_w_i)
    ,.valid_i(req_w_valid_i)
    ,.ready_o(req_w_ready_o)
    ,.data_o(req_head)
    ,.valid_o(req_head_valid)
    ,.ready_i(req_head_ready)
  );

  assign req_dest = req_head[mesh_pkg::pkt_x_lsb_lp +: mesh_pkg::x_width_lp];
  assign to_local = (req_dest == my_x_i);

  assign proc_req_o       = req_head;
  assign proc_req_valid_o = req_head_valid & to_local;
  assign req_e_o          = req_head;
  assign req_e_valid_o    = req_head_valid & ~to_local;
  assign req_head_ready   = to_local ? proc_req_ready_i : req_e_ready_i;

  link_fifo #(.depth(2)) resp_e_fifo (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.data_i(resp_e_i)
    ,.valid_i(resp_e_valid_i)
    ,.ready_o(resp_e_ready_o)
    ,.data_o(resp_e_head)
    ,.valid_o(resp_e_head_valid)
    ,.ready_i(resp_e_head_ready)
  );

  // Round robin, but a stalled grant stays put so the output holds stable
  always_comb begin
    if (hold_q) begin
      sel_e = hold_sel_e_q;
    end else if (resp_e_head_valid && proc_resp_valid_i) begin
      sel_e = prio_e_q;
    end else begin
      sel_e = resp_e_head_valid;
    end
  end

  assign resp_w_o          = sel_e ? resp_e_head : proc_resp_i;
  assign resp_w_valid_o    = sel_e ? resp_e_head_valid : proc_resp_valid_i;
  assign resp_e_head_ready = sel_e & resp_w_ready_i;
  assign proc_resp_ready_o = ~sel_e & resp_w_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prio_e_q     <= 1'b0;
      hold_q       <= 1'b0;
      hold_sel_e_q <= 1'b0;
    end else begin
      hold_q       <= resp_w_valid_o & ~resp_w_ready_i;
      hold_sel_e_q <= sel_e;
      if (resp_w_valid_o && resp_w_ready_i) prio_e_q <= ~sel_e;  // Other side next
    end
  end

  // Requests only move east, so one that left must target a tile further on
  a_east_beyond_me: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_e_valid_o |-> (req_dest > my_x_i))
    else $error("request for x %0d passed tile %0d", req_dest, my_x_i);

endmodule

//--- hdl/mesh_row.sv
/* Top of the tile row
   APB host bridge feeding a chain of tiles from the west end */
module mesh_row (
  input  logic                clk_i
  , input  logic                rst_n_i
  , input  logic [7:0]          paddr_i
  , input  logic                psel_i
  , input  logic                penable_i
  , input  logic                pwrite_i
  , input  mesh_pkg::data_t     pwdata_i
  , output mesh_pkg::data_t     prdata_o
  , output logic                pready_o
  , output logic                pslverr_o
);

  // Link i enters tile i from the west
  mesh_pkg::packet_t req_pkt    [mesh_pkg::num_tiles_lp+1];
  logic              req_valid  [mesh_pkg::num_tiles_lp+1];
  logic              req_ready  [mesh_pkg::num_tiles_lp+1];
  mesh_pkg::packet_t resp_pkt   [mesh_pkg::num_tiles_lp+1];
  logic              resp_valid [mesh_pkg::num_tiles_lp+1];
  logic              resp_ready [mesh_pkg::num_tiles_lp+1];

  apb_host_bridge host (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.paddr_i(paddr_i)
    ,.psel_i(psel_i)
    ,.penable_i(penable_i)
    ,.pwrite_i(pwrite_i)
    ,.pwdata_i(pwdata_i)
    ,.prdata_o(prdata_o)
    ,.pready_o(pready_o)
    ,.pslverr_o(pslverr_o)
    ,.req_o(req_pkt[0])
    ,.req_valid_o(req_valid[0])
    ,.req_ready_i(req_ready[0])
    ,.resp_i(resp_pkt[0])
    ,.resp_valid_i(resp_valid[0])
    ,.resp_ready_o(resp_ready[0])
  );

  // East end of the row is an idle link
  assign req_ready[mesh_pkg::num_tiles_lp]  = 1'b0;
  assign resp_pkt[mesh_pkg::num_tiles_lp]   = '0;
  assign resp_valid[mesh_pkg::num_tiles_lp] = 1'b0;

  for (genvar i = 0; i < mesh_pkg::num_tiles_lp; i++) begin : g_tile
    mesh_tile #(.x_cord(mesh_pkg::x_cord_t'(i))) tile (
      .clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.req_w_i(req_pkt[i])
      ,.req_w_valid_i(req_valid[i])
      ,.req_w_ready_o(req_ready[i])
      ,.req_e_o(req_pkt[i+1])
      ,.req_e_valid_o(req_valid[i+1])
      ,.req_e_ready_i(req_ready[i+1])
      ,.resp_e_i(resp_pkt[i+1])
      ,.resp_e_valid_i(resp_valid[i+1])
      ,.resp_e_ready_o(resp_ready[i+1])
      ,.resp_w_o(resp_pkt[i])
      ,.resp_w_valid_o(resp_valid[i])
      ,.resp_w_ready_i(resp_ready[i])
    );
  end

endmodule

//--- hdl/mesh_tile.sv
/* One tile of the row
   Local reset synchronizer, router node and memory socket */
module mesh_tile #(
  parameter mesh_pkg::x_cord_t x_cord = '0
) (
  input  logic                clk_i
  , input  logic                rst_n_i
  , input  mesh_pkg::packet_t   req_w_i
  , input  logic                req_w_valid_i
  , output logic                req_w_ready_o
  , output mesh_pkg::packet_t   req_e_o
  , output logic                req_e_valid_o
  , input  logic                req_e_ready_i
  , input  mesh_pkg::packet_t   resp_e_i
  , input  logic                resp_e_valid_i
  , output logic                resp_e_ready_o
  , output mesh_pkg::packet_t   resp_w_o
  , output logic                resp_w_valid_o
  , input  logic                resp_w_ready_i
);

  mesh_pkg::packet_t proc_req;
  logic              proc_req_valid;
  logic              proc_req_ready;
  mesh_pkg::packet_t proc_resp;
  logic              proc_resp_valid;
  logic              proc_resp_ready;

  // Reset is re-timed per tile since it fans out across the whole row
  logic [1:0] rst_sync_q;
  logic       tile_rst_n;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign tile_rst_n = rst_sync_q[1];

  mesh_router rtr (
    .clk_i(clk_i)
    ,.rst_n_i(tile_rst_n)
    ,.my_x_i(x_cord)
    ,.req_w_i(req_w_i)
    ,.req_w_valid_i(req_w_valid_i)
    ,.req_w_ready_o(req_w_ready_o)
    ,.req_e_o(req_e_o)
    ,.req_e_valid_o(req_e_valid_o)
    ,.req_e_ready_i(req_e_ready_i)
    ,.proc_req_o(proc_req)
    ,.proc_req_valid_o(proc_req_valid)
    ,.proc_req_ready_i(proc_req_ready)
    ,.proc_resp_i(proc_resp)
    ,.proc_resp_valid_i(proc_resp_valid)
    ,.proc_resp_ready_o(proc_resp_ready)
    ,.resp_e_i(resp_e_i)
    ,.resp_e_valid_i(resp_e_valid_i)
    ,.resp_e_ready_o(resp_e_ready_o)
    ,.resp_w_o(resp_w_o)
    ,.resp_w_valid_o(resp_w_valid_o)
    ,.resp_w_ready_i(resp_w_ready_i)
  );

  mem_socket proc (
    .clk_i(clk_i)
    ,.rst_n_i(tile_rst_n)
    ,.my_x_i(x_cord)
    ,.req_i(proc_req)
    ,.req_valid_i(proc_req_valid)
    ,.req_ready_o(proc_req_ready)
    ,.resp_o(proc_resp)
    ,.resp_valid_o(proc_resp_valid)
    ,.resp_ready_i(proc_resp_ready)
  );

endmodule

//--- tb.f
+incdir+include
hdl/mesh_pkg.sv
hdl/link_fifo.sv
hdl/mesh_router.sv
hdl/mem_socket.sv
hdl/mesh_tile.sv
hdl/apb_host_bridge.sv
hdl/mesh_row.sv
dv/mesh_row_tb.sv
